/* bench/hcalu_asserts.sv */
// Concurrent APB protocol and command sequencing assertions for apb_ctrl
`timescale 1ns/10ps

module hcalu_asserts import hcalu_pkg::*; (
	input logic        pclk,
	input logic        arst_n,
	input logic        psel,
	input logic        penable,
	input logic        pready,
	input logic        pslverr,
	input logic [31:0] prdata,
	input ctrl_state_e state,
	input logic        cmd_go
);
	int fail_count = 0;

	// Wait states come only from the EXEC cycle right after a CMD write
	a_pready_exec: assert property (@(posedge pclk) disable iff (!arst_n)
		!pready |-> (state == ST_EXEC) && $past(cmd_go))
	else begin
		$error("pready low outside ST_EXEC");
		fail_count = fail_count + 1;
	end

	// One stretched cycle, then the result is ready
	a_cmd_seq: assert property (@(posedge pclk) disable iff (!arst_n)
		cmd_go |=> (state == ST_EXEC && !pready) ##1 (state == ST_DONE && pready))
	else begin
		$error("CMD write not followed by ST_EXEC then ST_DONE");
		fail_count = fail_count + 1;
	end

	// A rejected access leaves the FSM where it was
	a_slverr_phase: assert property (@(posedge pclk) disable iff (!arst_n)
		pslverr |-> (psel && penable && pready) ##1 $stable(state))
	else begin
		$error("pslverr outside a completing access cycle");
		fail_count = fail_count + 1;
	end

	// Outputs at their reset values during reset
	a_reset_out: assert property (@(posedge pclk)
		!arst_n |-> (prdata == 32'h0 && pready && !pslverr))
	else begin
		$error("APB outputs not at reset values during reset");
		fail_count = fail_count + 1;
	end

endmodule

/* bench/hcalu_tb.sv */
// Testbench for hcalu_top with APB tasks, LFSR stimulus and reference model
`timescale 1ns/10ps
`include "hcalu_defs.svh"

module hcalu_tb import hcalu_pkg::*; ();
	localparam int MAX_CMDS    = 400;
	localparam int CYCLE_LIMIT = MAX_CMDS * 12 + 200;

	logic        pclk;
	logic        arst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [4:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [31:0] lfsr = 32'h90c5d994;
	int          cycles = 0;
	// Reference model state
	logic [11:0] exp_res;
	logic        exp_c;
	logic        exp_v;
	logic        exp_done;
	logic [7:0]  exp_cnt;

	hcalu_top DUT (.pclk(pclk), .arst_n(arst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr));

	bind apb_ctrl hcalu_asserts u_asserts (.pclk(pclk), .arst_n(arst_n), .psel(psel),
		.penable(penable), .pready(pready), .pslverr(pslverr), .prdata(prdata),
		.state(state), .cmd_go(cmd_go));

	initial begin
		pclk = 1'b0;
		forever #50 pclk = ~pclk;
	end

	always @(posedge pclk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d clock cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$fatal(1);
		end else if (DUT.u_ctrl.u_asserts.fail_count != 0) begin
			$display("A concurrent assertion on apb_ctrl failed");
			$display("Finished with errors");
			$fatal(1);
		end
	end

	// Taps 32, 22, 2, 1, one step per random bit
	function automatic logic [11:0] get_rand(input int n);
		logic [11:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[10:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int to_signed12(input logic [11:0] v);
		return v[11] ? int'(v) - 4096 : int'(v);
	endfunction

	task automatic check_hex(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		assert (act_val === exp_val)
		else begin
			$display("** Error: %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// One APB transfer, setup and access phases driven on falling edges
	task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
		input logic [31:0] exp_rd, input logic exp_err, input string name);
		@(negedge pclk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge pclk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			@(negedge pclk);
			#1;
		end
		check_hex("pslverr", {31'h0, exp_err}, {31'h0, pslverr});
		if (!wr)
			check_hex(name, exp_rd, prdata);
		@(posedge pclk);
	endtask

	function automatic logic [31:0] result_word();
		logic [31:0] w;
		w = {20'h0, exp_res};
		w[`HCALU_RES_C_BIT] = exp_c;
		w[`HCALU_RES_V_BIT] = exp_v;
		return w;
	endfunction

	function automatic logic [31:0] status_word();
		logic [31:0] w;
		w = '0;
		w[`HCALU_STAT_DONE_BIT] = exp_done;
		w[15:8] = exp_cnt;
		return w;
	endfunction

	task automatic model_exec(input op_e op, input logic [11:0] a, input logic [11:0] b);
		int t;
		int st;
		case (op)
			OP_ADD: begin
				t  = int'(a) + int'(b);
				st = to_signed12(a) + to_signed12(b);
			end
			OP_SUB: begin
				t  = int'(a) - int'(b);
				st = to_signed12(a) - to_signed12(b);
			end
			OP_ACC: begin
				t  = int'(exp_res) + int'(a);
				st = to_signed12(exp_res) + to_signed12(a);
			end
			default: begin
				t  = int'(a) + int'(b) + int'(exp_c);
				st = to_signed12(a) + to_signed12(b) + int'(exp_c);
			end
		endcase
		// Subtraction carry means no borrow
		exp_c    = (op == OP_SUB) ? (a >= b) : (t > 4095);
		exp_v    = (st > 2047) || (st < -2048);
		exp_res  = t[11:0];
		exp_cnt  = exp_cnt + 8'd1;
		exp_done = 1'b1;
	endtask

	task automatic run_cmd(input op_e op, input logic [11:0] a, input logic [11:0] b);
		apb_xfer(1'b1, `HCALU_ADDR_OPA, {20'h0, a}, '0, 1'b0, "");
		exp_done = 1'b0;
		apb_xfer(1'b0, `HCALU_ADDR_STAT, '0, status_word(), 1'b0, "prdata STATUS");
		apb_xfer(1'b1, `HCALU_ADDR_OPB, {20'h0, b}, '0, 1'b0, "");
		apb_xfer(1'b1, `HCALU_ADDR_CMD, {30'h0, op}, '0, 1'b0, "");
		model_exec(op, a, b);
		apb_xfer(1'b0, `HCALU_ADDR_RES, '0, result_word(), 1'b0, "prdata RESULT");
		apb_xfer(1'b0, `HCALU_ADDR_STAT, '0, status_word(), 1'b0, "prdata STATUS");
	endtask

	initial begin
		logic [11:0] corners [0:3];
		logic [11:0] a;
		logic [11:0] b;
		logic [11:0] r;
		corners  = '{12'h000, 12'hFFF, 12'h800, 12'h7FF};
		arst_n   = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		exp_res  = '0;
		exp_c    = 1'b0;
		exp_v    = 1'b0;
		exp_done = 1'b0;
		exp_cnt  = '0;
		@(negedge pclk);
		arst_n = 1'b0;
		repeat (8) @(posedge pclk);
		@(negedge pclk);
		arst_n = 1'b1;

		// Every register reads zero after reset
		apb_xfer(1'b0, `HCALU_ADDR_OPA, '0, '0, 1'b0, "prdata OPA");
		apb_xfer(1'b0, `HCALU_ADDR_OPB, '0, '0, 1'b0, "prdata OPB");
		apb_xfer(1'b0, `HCALU_ADDR_CMD, '0, '0, 1'b0, "prdata CMD");
		apb_xfer(1'b0, `HCALU_ADDR_RES, '0, '0, 1'b0, "prdata RESULT");
		apb_xfer(1'b0, `HCALU_ADDR_STAT, '0, '0, 1'b0, "prdata STATUS");

		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				run_cmd(OP_ADD, corners[i], corners[j]);
				run_cmd(OP_SUB, corners[i], corners[j]);
			end
		end
		repeat (40) begin
			a = get_rand(12);
			b = get_rand(12);
			run_cmd(OP_ADD, a, b);
			a = get_rand(12);
			b = get_rand(12);
			run_cmd(OP_SUB, a, b);
		end

		// Accumulate and add-with-carry chains, count wraps past 255
		repeat (160) begin
			a = get_rand(12);
			b = get_rand(12);
			r = get_rand(1);
			run_cmd(r[0] ? OP_ADC : OP_ACC, a, b);
		end

		// CMD writes straight from DONE chain without an idle cycle
		apb_xfer(1'b1, `HCALU_ADDR_CMD, {30'h0, OP_ACC}, '0, 1'b0, "");
		model_exec(OP_ACC, a, b);
		apb_xfer(1'b1, `HCALU_ADDR_CMD, {30'h0, OP_ADC}, '0, 1'b0, "");
		model_exec(OP_ADC, a, b);
		apb_xfer(1'b0, `HCALU_ADDR_RES, '0, result_word(), 1'b0, "prdata RESULT");
		apb_xfer(1'b0, `HCALU_ADDR_STAT, '0, status_word(), 1'b0, "prdata STATUS");

		// Rejected accesses change neither RESULT, count nor done
		apb_xfer(1'b1, 5'h14, 32'h0000_0123, '0, 1'b1, "");
		apb_xfer(1'b0, 5'h18, '0, '0, 1'b1, "prdata unmapped");
		apb_xfer(1'b1, `HCALU_ADDR_RES, 32'h0000_0abc, '0, 1'b1, "");
		apb_xfer(1'b1, `HCALU_ADDR_CMD, 32'h0000_0005, '0, 1'b1, "");
		apb_xfer(1'b0, `HCALU_ADDR_RES, '0, result_word(), 1'b0, "prdata RESULT");
		apb_xfer(1'b0, `HCALU_ADDR_STAT, '0, status_word(), 1'b0, "prdata STATUS");
		apb_xfer(1'b1, `HCALU_ADDR_OPA, '0, '0, 1'b0, "");
		exp_done = 1'b0;
		apb_xfer(1'b0, `HCALU_ADDR_STAT, '0, status_word(), 1'b0, "prdata STATUS");

		@(negedge pclk);
		if (DUT.u_ctrl.u_asserts.fail_count != 0) begin
			$display("Finished with errors");
			$fatal(1);
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* hcalu.f */
+incdir+hw
hw/hcalu_pkg.sv
hw/hc_prefix_tree.sv
hw/prefix_adder.sv
hw/alu_datapath.sv
hw/apb_ctrl.sv
hw/hcalu_top.sv
bench/hcalu_asserts.sv
bench/hcalu_tb.sv

/* hw/alu_datapath.sv */
// Operand selection per opcode, prefix adder and carry/overflow flags
`timescale 1ns/10ps
`include "hcalu_defs.svh"

module alu_datapath import hcalu_pkg::*; (
	input  op_e                 op,
	input  logic [`HCALU_W-1:0] opa,
	input  logic [`HCALU_W-1:0] opb,
	input  logic [`HCALU_W-1:0] acc,
	input  logic                carry_prev,
	output logic [`HCALU_W-1:0] sum,
	output logic                carry,
	output logic                overflow
);
	logic [`HCALU_W-1:0] x;
	logic [`HCALU_W-1:0] y;
	logic                cin;

	always_comb begin
		x   = opa;
		y   = opb;
		cin = 1'b0;
		case (op)
			OP_ADD: begin
				x   = opa;
				y   = opb;
			end
			// Two's complement, a + ~b + 1
			OP_SUB: begin
				y   = ~opb;
				cin = 1'b1;
			end
			OP_ACC: begin
				x   = acc;
				y   = opa;
			end
			OP_ADC: begin
				cin = carry_prev;
			end
			default: begin
				cin = 1'b0;
			end
		endcase
	end

	prefix_adder u_adder (
		.a    (x),
		.b    (y),
		.cin  (cin),
		.sum  (sum),
		.cout (carry)
	);

	// Same operand signs but result sign differs
	assign overflow = (x[`HCALU_W-1] == y[`HCALU_W-1]) &&
		(sum[`HCALU_W-1] != x[`HCALU_W-1]);

endmodule

/* hw/apb_ctrl.sv */
// APB slave decode, register bank and command sequencer of hcalu
`timescale 1ns/10ps
`include "hcalu_defs.svh"

module apb_ctrl import hcalu_pkg::*; (
	input  logic                pclk,
	input  logic                arst_n,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [4:0]          paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	output op_e                 op,
	output logic [`HCALU_W-1:0] opa,
	output logic [`HCALU_W-1:0] opb,
	output logic [`HCALU_W-1:0] acc,
	output logic                carry_prev,
	input  logic [`HCALU_W-1:0] sum,
	input  logic                carry,
	input  logic                overflow
);
	ctrl_state_e         state;
	logic [`HCALU_W-1:0] opa_q;
	logic [`HCALU_W-1:0] opb_q;
	logic [`HCALU_W-1:0] res_q;
	logic                c_q;
	logic                v_q;
	logic [7:0]          cnt_q;
	op_e                 op_q;
	logic                done;
	logic                xfer;
	logic                addr_hit;
	logic                err;
	logic                wr_ok;
	logic                cmd_go;
	logic [31:0]         rd_word;

	// Only the EXEC cycle stretches an access
	assign pready = (state != ST_EXEC);
	assign xfer   = psel && penable && pready;
	assign done   = (state == ST_DONE);

	always_comb begin
		case (paddr)
			`HCALU_ADDR_OPA, `HCALU_ADDR_OPB, `HCALU_ADDR_CMD,
			`HCALU_ADDR_RES, `HCALU_ADDR_STAT: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	end

	// Opcode field is pwdata[3:0], codes above OP_ADC are rejected
	assign err = !addr_hit ||
		(pwrite && (paddr == `HCALU_ADDR_RES || paddr == `HCALU_ADDR_STAT)) ||
		(pwrite && paddr == `HCALU_ADDR_CMD && pwdata[3:2] != 2'b00);

	assign pslverr = xfer && err;
	assign wr_ok   = xfer && pwrite && !err;
	assign cmd_go  = wr_ok && (paddr == `HCALU_ADDR_CMD);

	// Register bank and result capture
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			opa_q <= '0;
			opb_q <= '0;
			op_q  <= OP_ADD;
			res_q <= '0;
			c_q   <= 1'b0;
			v_q   <= 1'b0;
			cnt_q <= '0;
		end else begin
			if (wr_ok && paddr == `HCALU_ADDR_OPA)
				opa_q <= pwdata[`HCALU_W-1:0];
			if (wr_ok && paddr == `HCALU_ADDR_OPB)
				opb_q <= pwdata[`HCALU_W-1:0];
			if (cmd_go)
				op_q <= op_e'(pwdata[1:0]);
			if (state == ST_EXEC) begin
				res_q <= sum;
				c_q   <= carry;
				v_q   <= overflow;
				cnt_q <= cnt_q + 8'd1;
			end
		end
	end

	// Command FSM, a CMD write in DONE chains straight into EXEC
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (cmd_go) state <= ST_EXEC;
				ST_EXEC: state <= ST_DONE;
				ST_DONE: begin
					if (cmd_go)
						state <= ST_EXEC;
					else if (wr_ok)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_comb begin
		rd_word = '0;
		case (paddr)
			`HCALU_ADDR_OPA: rd_word[`HCALU_W-1:0] = opa_q;
			`HCALU_ADDR_OPB: rd_word[`HCALU_W-1:0] = opb_q;
			`HCALU_ADDR_CMD: rd_word[1:0] = op_q;
			`HCALU_ADDR_RES: begin
				rd_word[`HCALU_W-1:0]      = res_q;
				rd_word[`HCALU_RES_C_BIT] = c_q;
				rd_word[`HCALU_RES_V_BIT] = v_q;
			end
			`HCALU_ADDR_STAT: begin
				rd_word[`HCALU_STAT_DONE_BIT] = done;
				// Command count
				rd_word[15:8] = cnt_q;
			end
			default: rd_word = '0;
		endcase
	end

	assign prdata = (psel && penable && !pwrite) ? rd_word : '0;

	// Datapath operands
	assign op         = op_q;
	assign opa        = opa_q;
	assign opb        = opb_q;
	assign acc        = res_q;
	assign carry_prev = c_q;

endmodule

/* hw/hc_prefix_tree.sv */
// Han-Carlson prefix tree, bit propagate/generate to carries
`timescale 1ns/10ps
`include "hcalu_defs.svh"

module hc_prefix_tree (
	input  logic [`HCALU_W-1:0] p,
	input  logic [`HCALU_W-1:0] g,
	output logic [`HCALU_W:1]   c
);
	// Span 1, odd positions
	logic g_1_0;
	logic g_3_2, p_3_2, g_5_4, p_5_4, g_7_6, p_7_6;
	logic g_9_8, p_9_8, g_11_10, p_11_10;
	// Span 2
	logic g_3_0;
	logic g_5_2, p_5_2, g_7_4, p_7_4, g_9_6, p_9_6, g_11_8, p_11_8;
	// Span 4
	logic g_5_0, g_7_0;
	logic g_9_2, p_9_2, g_11_4, p_11_4;
	// Span 8
	logic g_9_0, g_11_0;
	// Even positions from the extra grey row
	logic g_2_0, g_4_0, g_6_0, g_8_0, g_10_0;

	// Stage 1
	assign g_1_0   = g[1] | (p[1] & g[0]);
	assign g_3_2   = g[3] | (p[3] & g[2]);
	assign p_3_2   = p[3] & p[2];
	assign g_5_4   = g[5] | (p[5] & g[4]);
	assign p_5_4   = p[5] & p[4];
	assign g_7_6   = g[7] | (p[7] & g[6]);
	assign p_7_6   = p[7] & p[6];
	assign g_9_8   = g[9] | (p[9] & g[8]);
	assign p_9_8   = p[9] & p[8];
	assign g_11_10 = g[11] | (p[11] & g[10]);
	assign p_11_10 = p[11] & p[10];

	// Stage 2
	assign g_3_0  = g_3_2 | (p_3_2 & g_1_0);
	assign g_5_2  = g_5_4 | (p_5_4 & g_3_2);
	assign p_5_2  = p_5_4 & p_3_2;
	assign g_7_4  = g_7_6 | (p_7_6 & g_5_4);
	assign p_7_4  = p_7_6 & p_5_4;
	assign g_9_6  = g_9_8 | (p_9_8 & g_7_6);
	assign p_9_6  = p_9_8 & p_7_6;
	assign g_11_8 = g_11_10 | (p_11_10 & g_9_8);
	assign p_11_8 = p_11_10 & p_9_8;

	// Stage 3
	assign g_5_0  = g_5_2 | (p_5_2 & g_1_0);
	assign g_7_0  = g_7_4 | (p_7_4 & g_3_0);
	assign g_9_2  = g_9_6 | (p_9_6 & g_5_2);
	assign p_9_2  = p_9_6 & p_5_2;
	assign g_11_4 = g_11_8 | (p_11_8 & g_7_4);
	assign p_11_4 = p_11_8 & p_7_4;

	// Stage 4
	assign g_9_0  = g_9_2 | (p_9_2 & g_1_0);
	assign g_11_0 = g_11_4 | (p_11_4 & g_3_0);

	// Extra grey row
	assign g_2_0  = g[2] | (p[2] & g_1_0);
	assign g_4_0  = g[4] | (p[4] & g_3_0);
	assign g_6_0  = g[6] | (p[6] & g_5_0);
	assign g_8_0  = g[8] | (p[8] & g_7_0);
	assign g_10_0 = g[10] | (p[10] & g_9_0);

	// c[k+1] is the group generate from k down to 0
	assign c = {g_11_0, g_10_0, g_9_0, g_8_0, g_7_0, g_6_0,
		g_5_0, g_4_0, g_3_0, g_2_0, g_1_0, g[0]};

endmodule

/* hw/hcalu_defs.svh */
// Data width, APB register offsets and bit positions for the hcalu peripheral
`ifndef HCALU_DEFS_SVH
`define HCALU_DEFS_SVH

// Operand and result width
`define HCALU_W 12

// Register byte offsets on the 5-bit APB address
`define HCALU_ADDR_OPA  5'h00
`define HCALU_ADDR_OPB  5'h04
`define HCALU_ADDR_CMD  5'h08
`define HCALU_ADDR_RES  5'h0C
`define HCALU_ADDR_STAT 5'h10

// Flag positions in the RESULT read word
`define HCALU_RES_C_BIT 12
`define HCALU_RES_V_BIT 13

// Done flag in STATUS, command count sits in bits 15:8
`define HCALU_STAT_DONE_BIT 0

`endif

/* hw/hcalu_pkg.sv */
// Opcode and control state enums shared by the hcalu design
package hcalu_pkg;

	// Command opcodes, written to CMD bits 3:0
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_ACC = 2'd2,
		OP_ADC = 2'd3
	} op_e;

	// Command sequencing in apb_ctrl
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_EXEC = 2'd1,
		ST_DONE = 2'd2
	} ctrl_state_e;

endpackage

/* hw/hcalu_top.sv */
// Top level of hcalu, APB control and arithmetic datapath
`timescale 1ns/10ps
`include "hcalu_defs.svh"

module hcalu_top import hcalu_pkg::*; (
	input  logic        pclk,
	input  logic        arst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [4:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);
	op_e                 op;
	logic [`HCALU_W-1:0] opa;
	logic [`HCALU_W-1:0] opb;
	logic [`HCALU_W-1:0] acc;
	logic                carry_prev;
	logic [`HCALU_W-1:0] sum;
	logic                carry;
	logic                overflow;

	apb_ctrl u_ctrl (
		.pclk       (pclk),
		.arst_n     (arst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.op         (op),
		.opa        (opa),
		.opb        (opb),
		.acc        (acc),
		.carry_prev (carry_prev),
		.sum        (sum),
		.carry      (carry),
		.overflow   (overflow)
	);

	alu_datapath u_dp (
		.op         (op),
		.opa        (opa),
		.opb        (opb),
		.acc        (acc),
		.carry_prev (carry_prev),
		.sum        (sum),
		.carry      (carry),
		.overflow   (overflow)
	);

endmodule

/* hw/prefix_adder.sv */
// Han-Carlson adder, pre-computation, prefix tree and post-computation
`timescale 1ns/10ps
`include "hcalu_defs.svh"

module prefix_adder (
	input  logic [`HCALU_W-1:0] a,
	input  logic [`HCALU_W-1:0] b,
	input  logic                cin,
	output logic [`HCALU_W-1:0] sum,
	output logic                cout
);
	// Extended by one position, carry in acts as generate of position 0
	logic [`HCALU_W:0]   p_ext;
	logic [`HCALU_W:0]   g_ext;
	logic [`HCALU_W:1]   c;

	assign p_ext = {a ^ b, 1'b0};
	assign g_ext = {a & b, cin};

	hc_prefix_tree u_tree (
		.p (p_ext[`HCALU_W-1:0]),
		.g (g_ext[`HCALU_W-1:0]),
		.c (c)
	);

	// Sum bit i sees the carry into extended position i+1
	assign sum  = p_ext[`HCALU_W:1] ^ c;
	assign cout = g_ext[`HCALU_W] | (p_ext[`HCALU_W] & c[`HCALU_W]);

endmodule
